/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ipv4_tb
FILELIST = sim.f
BUILD    = obj_dir

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD)

/* sim.f */
source/eth_pkg.sv
source/ipv4_pkg.sv
source/ipv4_csum.sv
source/ipv4_rx.sv
source/ipv4_tx.sv
source/ipv4_top.sv
verification/ipv4_props.sv
verification/ipv4_tb.sv

/* source/eth_pkg.sv */
package eth_pkg;

	typedef logic [47:0] mac_addr_t;

	// Only the two types this stack has to tell apart
	typedef enum logic [15:0] {
		IPV4 = 16'h0800,
		ARP  = 16'h0806
	} ethertype_t;

	// Ethernet header as seen by the layer above the MAC
	typedef struct packed {
		mac_addr_t   dst_mac_addr;
		mac_addr_t   src_mac_addr;
		ethertype_t  ethertype;
		logic [15:0] length;       // Length of the carried IPv4 packet
	} mac_hdr_t;

	// Own addresses of the device
	typedef struct packed {
		mac_addr_t   mac_addr;
		logic [31:0] ipv4_addr;
	} dev_t;

	// Byte stream to and from the MAC
	typedef struct packed {
		logic [7:0] d;
		logic       v;   // Qualifies d
		logic       sof; // First byte after the Ethernet header
		logic       eof; // Last byte of the frame
		logic       err;
		mac_hdr_t   hdr;
	} mac_stream_t;

endpackage

/* source/ipv4_csum.sv */
`timescale 1ns/1ns

module ipv4_csum (
	input  logic        clk,
	input  logic        fsm_rst,
	input  logic        clear,
	input  logic        add,
	input  logic [15:0] word,
	output logic [15:0] sum
);

	logic [18:0] acc;
	logic [16:0] fold;

	// Carries above bit 15 are folded back in on every add,
	// so the accumulator never overflows however many words arrive
	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			acc <= '0;
		end
		else if (clear) begin
			acc <= add ? {3'b000, word} : '0; // Restart, optionally with a first word
		end
		else if (add) begin
			acc <= {3'b000, acc[15:0]} + {16'h0000, acc[18:16]} + {3'b000, word};
		end
	end

	// End-around carry, twice
	assign fold = {1'b0, acc[15:0]} + {14'h0000, acc[18:16]};
	assign sum  = fold[15:0] + {15'h0000, fold[16]}; // Not inverted

endmodule

/* source/ipv4_pkg.sv */
package ipv4_pkg;

	localparam int         IPV4_HDR_LEN = 20;    // Header bytes, no options
	localparam logic [3:0] IPV4_VER     = 4'd4;
	localparam logic [3:0] IPV4_IHL     = 4'd5;  // In 32-bit words

	typedef logic [31:0] ipv4_t;

	// Header fields in the order they appear on the wire, 160 bits
	typedef struct packed {
		logic [3:0]  ver;
		logic [3:0]  ihl;
		logic [7:0]  qos;
		logic [15:0] length;   // Total length, header included
		logic [15:0] id;
		logic        rsv;      // Reserved flag bit, always zero
		logic        df;
		logic        mf;
		logic [12:0] fo;       // Fragment offset in 8-byte units
		logic [7:0]  ttl;
		logic [7:0]  proto;
		logic [15:0] checksum;
		ipv4_t       src_ip;
		ipv4_t       dst_ip;
	} ipv4_hdr_t;

	// Fragment info derived from the header
	typedef struct packed {
		logic [15:0] pl_len; // Payload bytes in this packet
		logic        nf;     // Not fragmented
		logic [15:0] fin;    // Byte offset just past this fragment
	} ipv4_frag_t;

	// Byte stream to and from the upper layer
	typedef struct packed {
		logic [7:0] d;
		logic       v;
		logic       sof;
		logic       eof;
		logic       err;
		ipv4_hdr_t  hdr;
		ipv4_frag_t frag;
	} ipv4_stream_t;

	typedef enum logic [2:0] {
		IDLE,
		CALC,      // Two header bytes per cycle into the checksum
		ARP_WAIT,
		HDR,       // Header bytes out on the MAC
		PAYLOAD
	} ipv4_tx_state_t;

endpackage

/* source/ipv4_rx.sv */
`timescale 1ns/1ns

module ipv4_rx (
	input  logic                   clk,
	input  logic                   fsm_rst,
	input  eth_pkg::mac_stream_t   mac_rx,
	input  eth_pkg::dev_t          dev,
	output ipv4_pkg::ipv4_stream_t ipv4_rx_o
);

	import eth_pkg::*;
	import ipv4_pkg::*;

	logic                         start;
	logic                         in_pkt;
	logic                         pkt_end;
	logic                         pkt_rst;
	logic                         receiving;
	logic [15:0]                  byte_cnt;   // IPv4 bytes seen before the current one
	logic                         hdr_last;
	logic                         hdr_done;
	logic                         frag_calc;
	logic [IPV4_HDR_LEN-2:0][7:0] hdr_sr;
	ipv4_hdr_t                    hdr_next;
	logic                         csum_add;
	logic [15:0]                  csum_sum;
	logic                         addr_ok;
	logic                         hdr_ok;
	logic                         pass;

	logic [7:0]                   out_d;
	logic                         out_v;
	logic                         out_sof;
	logic                         out_eof;
	logic                         out_err;
	ipv4_hdr_t                    hdr_q;
	ipv4_frag_t                   frag_q;

	assign start    = mac_rx.v && mac_rx.sof && (mac_rx.hdr.ethertype == IPV4);
	assign in_pkt   = mac_rx.v && (receiving || start);
	assign pkt_end  = in_pkt && (mac_rx.eof || mac_rx.err);
	assign pkt_rst  = fsm_rst || pkt_end; // Packet reset after the last byte
	assign hdr_last = in_pkt && (byte_cnt == 16'(IPV4_HDR_LEN - 1));
	assign hdr_next = {hdr_sr, mac_rx.d}; // Complete header on the 20th byte

	// Previous byte is the high half of each header word
	assign csum_add = in_pkt && byte_cnt[0] && (byte_cnt < 16'(IPV4_HDR_LEN));

	ipv4_csum csum_i (
		.clk     (clk),
		.fsm_rst (fsm_rst),
		.clear   (start),
		.add     (csum_add),
		.word    ({hdr_sr[0], mac_rx.d}),
		.sum     (csum_sum)
	);

	assign addr_ok = (hdr_q.dst_ip == dev.ipv4_addr) || (hdr_q.dst_ip == '1);
	assign hdr_ok  = hdr_done && (csum_sum == 16'hffff);
	assign pass    = in_pkt && hdr_done && addr_ok;

	always_ff @(posedge clk) begin
		if (pkt_rst) begin
			receiving <= 1'b0;
			byte_cnt  <= '0;
			hdr_done  <= 1'b0;
		end
		else if (in_pkt) begin
			receiving <= 1'b1;
			byte_cnt  <= byte_cnt + 16'd1;
			if (hdr_last) hdr_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fsm_rst) frag_calc <= 1'b0;
		else frag_calc <= hdr_last; // nf and fin one cycle after the header
	end

	// Header and fragment info stay put until the next header completes
	always_ff @(posedge clk) begin
		if (in_pkt) hdr_sr <= {hdr_sr[IPV4_HDR_LEN-3:0], mac_rx.d};
		if (hdr_last) begin
			hdr_q         <= hdr_next;
			frag_q.pl_len <= hdr_next.length - 16'(IPV4_HDR_LEN);
		end
		if (frag_calc) begin
			frag_q.nf  <= (hdr_q.fo == '0) && !hdr_q.mf;
			frag_q.fin <= {hdr_q.fo, 3'b000} + frag_q.pl_len;
		end
		out_d <= mac_rx.d;
	end

	// eof and err are reported even when the filter drops the payload
	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			out_v   <= 1'b0;
			out_sof <= 1'b0;
			out_eof <= 1'b0;
			out_err <= 1'b0;
		end
		else begin
			out_v   <= pass;
			out_sof <= pass && (byte_cnt == 16'(IPV4_HDR_LEN));
			out_eof <= pkt_end;
			out_err <= pkt_end && (mac_rx.err || !hdr_ok);
		end
	end

	assign ipv4_rx_o = '{d: out_d, v: out_v, sof: out_sof, eof: out_eof, err: out_err,
		hdr: hdr_q, frag: frag_q};

endmodule

/* source/ipv4_top.sv */
`timescale 1ns/1ns

module ipv4_top (
	input  logic                   clk,
	input  logic                   fsm_rst,
	input  eth_pkg::dev_t          dev,
	input  eth_pkg::mac_stream_t   mac_rx,
	output ipv4_pkg::ipv4_stream_t ipv4_rx_o,
	input  logic                   avl,
	input  ipv4_pkg::ipv4_stream_t ipv4_tx_i,
	output logic                   busy,
	output logic                   rdy,
	output ipv4_pkg::ipv4_t        ipv4_req,
	input  eth_pkg::mac_addr_t     mac_rsp,
	input  logic                   arp_val,
	input  logic                   arp_err,
	output logic                   rst_fifo,
	output eth_pkg::mac_stream_t   mac_tx
);

	ipv4_rx rx_i (
		.clk       (clk),
		.fsm_rst   (fsm_rst),
		.mac_rx    (mac_rx),
		.dev       (dev),
		.ipv4_rx_o (ipv4_rx_o)
	);

	// ARP lookup is answered outside the stack
	ipv4_tx tx_i (
		.clk       (clk),
		.fsm_rst   (fsm_rst),
		.dev       (dev),
		.avl       (avl),
		.ipv4_tx_i (ipv4_tx_i),
		.busy      (busy),
		.rdy       (rdy),
		.ipv4_req  (ipv4_req),
		.mac_rsp   (mac_rsp),
		.arp_val   (arp_val),
		.arp_err   (arp_err),
		.rst_fifo  (rst_fifo),
		.mac_tx    (mac_tx)
	);

endmodule

/* source/ipv4_tx.sv */
`timescale 1ns/1ns

module ipv4_tx (
	input  logic                   clk,
	input  logic                   fsm_rst,
	input  eth_pkg::dev_t          dev,
	input  logic                   avl,
	input  ipv4_pkg::ipv4_stream_t ipv4_tx_i,
	output logic                   busy,
	output logic                   rdy,
	output ipv4_pkg::ipv4_t        ipv4_req,
	input  eth_pkg::mac_addr_t     mac_rsp,
	input  logic                   arp_val,
	input  logic                   arp_err,
	output logic                   rst_fifo,
	output eth_pkg::mac_stream_t   mac_tx
);

	import eth_pkg::*;
	import ipv4_pkg::*;

	ipv4_tx_state_t               state;
	logic [4:0]                   cnt;
	logic                         latch;
	logic                         arp_go;
	logic                         pkt_rst;
	ipv4_hdr_t                    hdr_in;
	logic [IPV4_HDR_LEN-1:0][7:0] hdr_b;    // Byte 19 goes out first
	logic [15:0]                  csum_sum;

	logic [7:0]                   tx_d;
	logic                         tx_v;
	logic                         tx_sof;
	logic                         tx_eof;
	mac_hdr_t                     tx_hdr;

	assign latch   = (state == IDLE) && avl;
	assign arp_go  = (state == ARP_WAIT) && arp_val && !arp_err;
	assign pkt_rst = fsm_rst || ((state == ARP_WAIT) && arp_err) ||
		((state == PAYLOAD) && ipv4_tx_i.eof);
	assign busy    = (state != IDLE);

	// Fixed fields filled in, source address is always our own
	always_comb begin
		hdr_in          = ipv4_tx_i.hdr;
		hdr_in.ver      = IPV4_VER;
		hdr_in.ihl      = IPV4_IHL;
		hdr_in.rsv      = 1'b0;
		hdr_in.checksum = '0;
		hdr_in.src_ip   = dev.ipv4_addr;
	end

	ipv4_csum csum_i (
		.clk     (clk),
		.fsm_rst (fsm_rst),
		.clear   (latch),
		.add     (state == CALC),
		.word    (hdr_b[IPV4_HDR_LEN-1 -: 2]),
		.sum     (csum_sum)
	);

	always_ff @(posedge clk) begin
		if (pkt_rst) begin
			state    <= IDLE;
			cnt      <= '0;
			rdy      <= 1'b0;
			ipv4_req <= '0;
		end
		else begin
			rdy <= 1'b0;
			case (state)
				IDLE: if (avl) begin
					state    <= CALC;
					ipv4_req <= ipv4_tx_i.hdr.dst_ip; // Held for the ARP table
				end
				CALC: begin
					cnt <= cnt + 5'd1;
					if (cnt == 5'd9) begin  // Ten words summed
						cnt   <= '0;
						state <= ARP_WAIT;
					end
				end
				ARP_WAIT: if (arp_go) begin
					state <= HDR;
					cnt   <= 5'd1;          // First byte leaves on this edge
				end
				HDR: begin
					cnt <= cnt + 5'd1;
					// Payload source needs two cycles, so ask along with byte 18
					rdy <= (cnt == 5'(IPV4_HDR_LEN - 3));
					if (cnt == 5'(IPV4_HDR_LEN - 1)) state <= PAYLOAD;
				end
				PAYLOAD: ;                  // Left by eof through the packet reset
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (latch) begin
			hdr_b <= hdr_in;
		end
		else if (state == CALC) begin
			// Rotate by one word, ten of them bring the header back in place
			hdr_b <= {hdr_b[IPV4_HDR_LEN-3:0], hdr_b[IPV4_HDR_LEN-1 -: 2]};
		end
		else if (arp_go) begin
			// Shift out byte 19 and drop the inverted checksum into bytes 10 and 11
			hdr_b  <= {hdr_b[18:10], ~csum_sum, hdr_b[7:0], 8'h00};
			tx_hdr <= '{dst_mac_addr: mac_rsp, src_mac_addr: dev.mac_addr,
				ethertype: IPV4, length: hdr_b[17:16]};
		end
		else if (state == HDR) begin
			hdr_b <= {hdr_b[IPV4_HDR_LEN-2:0], 8'h00};
		end
		tx_d <= (state == PAYLOAD) ? ipv4_tx_i.d : hdr_b[IPV4_HDR_LEN-1];
	end

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			tx_v     <= 1'b0;
			tx_sof   <= 1'b0;
			tx_eof   <= 1'b0;
			rst_fifo <= 1'b0;
		end
		else begin
			tx_v     <= arp_go || (state == HDR) || (state == PAYLOAD);
			tx_sof   <= arp_go;
			tx_eof   <= (state == PAYLOAD) && ipv4_tx_i.eof;
			rst_fifo <= (state == ARP_WAIT) && arp_err; // Drop the buffered payload
		end
	end

	assign mac_tx = '{d: tx_d, v: tx_v, sof: tx_sof, eof: tx_eof, err: 1'b0, hdr: tx_hdr};

endmodule

/* verification/ipv4_props.sv */
`timescale 1ns/1ns

module ipv4_props (
	input logic                 clk,
	input logic                 fsm_rst,
	input logic                 rdy,
	input logic                 busy,
	input logic                 rst_fifo,
	input eth_pkg::mac_stream_t mac_tx
);

	// Payload request is a single strobe
	assert property (@(posedge clk) disable iff (fsm_rst) rdy |=> !rdy)
		else $error("rdy held for more than one cycle");

	// sof only on the first valid byte of a frame
	assert property (@(posedge clk) disable iff (fsm_rst)
		mac_tx.sof |-> mac_tx.v && !$past(mac_tx.v))
		else $error("mac_tx.sof without mac_tx.v or inside a frame");

	// Output bytes are registered, so the FSM was out of IDLE one cycle earlier
	assert property (@(posedge clk) disable iff (fsm_rst) mac_tx.v |-> $past(busy))
		else $error("mac_tx.v while the transmit FSM was idle");

	assert property (@(posedge clk) disable iff (fsm_rst) $fell(busy) |-> mac_tx.eof || rst_fifo)
		else $error("busy dropped before eof or rst_fifo");

endmodule

bind ipv4_top ipv4_props props_i (
	.clk      (clk),
	.fsm_rst  (fsm_rst),
	.rdy      (rdy),
	.busy     (busy),
	.rst_fifo (rst_fifo),
	.mac_tx   (mac_tx)
);

/* verification/ipv4_stim.txt */
# All columns hex: dst_ip id ttl proto payload_len arp_err corrupt
# arp_err 1 abandons the packet, corrupt 1 flips a header byte on the loopback
c0a80001 1001 40 11 10 0 0
ffffffff 1002 40 11 08 0 0
c0a80099 1003 20 06 0c 0 0
c0a80001 1004 40 11 10 1 0
c0a80001 1005 80 06 05 0 0
c0a80001 1006 40 11 20 0 1
ffffffff 1007 01 01 02 0 0
0a000001 1008 40 11 03 0 0
c0a80001 1009 ff 06 40 0 0
c0a80001 100a 40 11 01 0 0

/* verification/ipv4_tb.sv */
`timescale 1ns/1ns

module ipv4_tb;

	import eth_pkg::*;
	import ipv4_pkg::*;

	// One line of the stimulus file
	typedef struct packed {
		ipv4_t       dst;
		logic [15:0] id;
		logic [7:0]  ttl;
		logic [7:0]  proto;
		logic [15:0] plen;
		logic        arp_fail;
		logic        corrupt;
	} stim_t;

	logic         clk;
	logic         fsm_rst;
	dev_t         dev;
	mac_stream_t  mac_rx = '0;
	ipv4_stream_t ipv4_rx_o;
	logic         avl;
	ipv4_stream_t tx_in;
	logic         busy;
	logic         rdy;
	ipv4_t        ipv4_req;
	mac_addr_t    mac_rsp;
	logic         arp_val;
	logic         arp_err;
	logic         rst_fifo;
	mac_stream_t  mac_tx;

	stim_t      stim_q[$];
	logic [7:0] exp_bytes[$];    // Header then payload, as sent on the MAC
	ipv4_hdr_t  exp_hdr;
	mac_addr_t  exp_mac;
	int         exp_plen;
	logic       exp_pass = 1'b0;
	logic       exp_corrupt = 1'b0;
	logic       exp_drop = 1'b1;
	int         tx_idx;
	int         rx_idx;
	int         lb_idx;
	logic       tx_done;
	logic       rx_done;
	int         seed = 70888;
	int         cycles = 0;
	int         limit = 0;

	ipv4_top dut_i (
		.clk(clk), .fsm_rst(fsm_rst), .dev(dev), .mac_rx(mac_rx), .ipv4_rx_o(ipv4_rx_o),
		.avl(avl), .ipv4_tx_i(tx_in), .busy(busy), .rdy(rdy), .ipv4_req(ipv4_req),
		.mac_rsp(mac_rsp), .arp_val(arp_val), .arp_err(arp_err), .rst_fifo(rst_fifo),
		.mac_tx(mac_tx)
	);

	task automatic check(input string name, input logic [159:0] got, input logic [159:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail(input string msg);
		$display("%0t ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "run aborted");
	endtask

	// Header as the DUT must send it, checksum over ten words with end-around carry
	function automatic ipv4_hdr_t build_hdr(input stim_t s);
		ipv4_hdr_t   h;
		logic [31:0] acc;
		int          i;
		h          = '0;
		h.ver      = IPV4_VER;
		h.ihl      = IPV4_IHL;
		h.length   = 16'(IPV4_HDR_LEN) + s.plen;
		h.id       = s.id;
		h.df       = 1'b1;
		h.ttl      = s.ttl;
		h.proto    = s.proto;
		h.src_ip   = dev.ipv4_addr;
		h.dst_ip   = s.dst;
		acc        = '0;
		for (i = 0; i < 10; i++) acc = acc + {16'h0000, h[159-16*i -: 16]};
		acc        = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
		acc        = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
		h.checksum = ~acc[15:0];
		return h;
	endfunction

	task automatic read_stim();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f[7];
		stim_t       s;
		fd = $fopen("verification/ipv4_stim.txt", "r");
		if (fd == 0) fail("cannot open the stimulus file verification/ipv4_stim.txt");
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0) break;
			if (line.len() < 2 || line[0] == 8'h23) continue; // Comment or blank
			n = $sscanf(line, "%h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
			if (n == 7) begin
				s = '{dst: f[0], id: f[1][15:0], ttl: f[2][7:0], proto: f[3][7:0],
					plen: f[4][15:0], arp_fail: f[5][0], corrupt: f[6][0]};
				stim_q.push_back(s);
			end
		end
		$fclose(fd);
	endtask

	task automatic send_packet(input stim_t s);
		ipv4_hdr_t h;
		int        w;
		int        k;
		h = build_hdr(s);
		exp_bytes.delete();
		for (k = 0; k < IPV4_HDR_LEN; k++) exp_bytes.push_back(h[159-8*k -: 8]);
		for (k = 0; k < int'(s.plen); k++) exp_bytes.push_back(8'($random(seed)));
		exp_hdr     = h;
		exp_plen    = int'(s.plen);
		exp_pass    = (s.dst == dev.ipv4_addr) || (s.dst == '1);
		exp_corrupt = s.corrupt;
		exp_drop    = s.arp_fail;
		tx_idx      = 0;
		rx_idx      = 0;
		tx_done     = 1'b0;
		rx_done     = 1'b0;
		tx_in.hdr   = h;
		tx_in.hdr.checksum = '0; // Upper layer leaves it blank
		avl = 1'b1;
		@(negedge clk);
		avl = 1'b0;
		check("busy", 160'(busy), 160'(1'b1));
		check("ipv4_req", 160'(ipv4_req), 160'(s.dst));
		w = int'($unsigned($random(seed)) % 8);
		repeat (10 + w) @(negedge clk);   // Checksum cycles, then the ARP delay
		if (s.arp_fail) begin
			arp_err = 1'b1;
			@(negedge clk);
			arp_err = 1'b0;
			check("rst_fifo", 160'(rst_fifo), 160'(1'b1));
			check("busy", 160'(busy), 160'(1'b0));
			@(negedge clk);
			check("rst_fifo", 160'(rst_fifo), 160'(1'b0));
			repeat (4) @(negedge clk);
		end
		else begin
			mac_rsp = {16'h02aa, 32'($random(seed))};
			exp_mac = mac_rsp;
			arp_val = 1'b1;
			@(negedge clk);
			arp_val = 1'b0;
			while (!rdy) @(negedge clk);
			repeat (2) @(negedge clk);     // First payload byte two cycles after rdy
			for (k = 0; k < exp_plen; k++) begin
				tx_in.d   = exp_bytes[IPV4_HDR_LEN + k];
				tx_in.eof = (k == exp_plen - 1);
				@(negedge clk);
			end
			tx_in.eof = 1'b0;
			while (!(tx_done && rx_done)) @(negedge clk);
			check("busy", 160'(busy), 160'(1'b0));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	// Loopback from the transmit MAC into the receive MAC, one header byte flipped on request
	always @(negedge clk) begin
		mac_stream_t lb;
		lb = mac_tx;
		if (mac_tx.v) begin
			lb_idx = mac_tx.sof ? 0 : lb_idx + 1;
			if (exp_corrupt && lb_idx == 4) lb.d = lb.d ^ 8'h10;
		end
		mac_rx <= lb;
	end

	always @(negedge clk) begin
		if (mac_tx.v) begin
			if (exp_drop || tx_idx >= exp_bytes.size())
				fail("mac_tx sent a byte that was not expected");
			check("mac_tx.sof", 160'(mac_tx.sof), 160'(tx_idx == 0));
			check("mac_tx.err", 160'(mac_tx.err), 160'(1'b0));
			check("rdy", 160'(rdy), 160'(tx_idx == IPV4_HDR_LEN - 3)); // With the 18th byte
			if (tx_idx == 0) begin
				check("mac_tx.hdr.dst_mac_addr", 160'(mac_tx.hdr.dst_mac_addr), 160'(exp_mac));
				check("mac_tx.hdr.src_mac_addr", 160'(mac_tx.hdr.src_mac_addr),
					160'(dev.mac_addr));
				check("mac_tx.hdr.ethertype", 160'(mac_tx.hdr.ethertype), 160'(16'h0800));
				check("mac_tx.hdr.length", 160'(mac_tx.hdr.length), 160'(exp_hdr.length));
			end
			check("mac_tx.d", 160'(mac_tx.d), 160'(exp_bytes[tx_idx]));
			check("mac_tx.eof", 160'(mac_tx.eof), 160'(tx_idx == exp_bytes.size() - 1));
			if (mac_tx.eof) tx_done = 1'b1;
			tx_idx = tx_idx + 1;
		end
	end

	always @(negedge clk) begin
		if (ipv4_rx_o.v) begin
			if (!exp_pass) fail("payload passed the address filter for a foreign destination");
			if (rx_idx >= exp_plen) fail("ipv4_rx_o delivered more payload bytes than sent");
			check("ipv4_rx_o.sof", 160'(ipv4_rx_o.sof), 160'(rx_idx == 0));
			check("ipv4_rx_o.d", 160'(ipv4_rx_o.d), 160'(exp_bytes[IPV4_HDR_LEN + rx_idx]));
			rx_idx = rx_idx + 1;
		end
		if (ipv4_rx_o.eof) begin
			if (exp_drop) fail("receive side reported a packet that was never sent");
			check("ipv4_rx_o.v", 160'(ipv4_rx_o.v), 160'(exp_pass)); // eof on the last byte
			check("ipv4_rx_o.err", 160'(ipv4_rx_o.err), 160'(exp_corrupt));
			if (!exp_corrupt) begin
				check("ipv4_rx_o.hdr", 160'(ipv4_rx_o.hdr), 160'(exp_hdr));
				check("ipv4_rx_o.frag.pl_len", 160'(ipv4_rx_o.frag.pl_len), 160'(exp_plen));
				check("ipv4_rx_o.frag.nf", 160'(ipv4_rx_o.frag.nf),
					160'(exp_hdr.fo == '0 && !exp_hdr.mf));
				check("ipv4_rx_o.frag.fin", 160'(ipv4_rx_o.frag.fin),
					160'({exp_hdr.fo, 3'b000} + 16'(exp_plen)));
			end
			check("payload byte count", 160'(rx_idx), 160'(exp_pass ? exp_plen : 0));
			rx_done = 1'b1;
		end
	end

	initial begin
		dev     = '{mac_addr: 48'h02_00_00_00_00_01, ipv4_addr: 32'hc0a8_0001};
		fsm_rst = 1'b1;
		avl     = 1'b0;
		tx_in   = '0;
		mac_rsp = '0;
		arp_val = 1'b0;
		arp_err = 1'b0;
		read_stim();
		foreach (stim_q[i]) limit = limit + 40 + int'(stim_q[i].plen) + 8;
		limit = limit + 16 + 100; // Reset and slack
		repeat (16) @(negedge clk);
		fsm_rst = 1'b0;
		check("busy", 160'(busy), 160'(1'b0));
		check("rdy", 160'(rdy), 160'(1'b0));
		check("rst_fifo", 160'(rst_fifo), 160'(1'b0));
		check("ipv4_req", 160'(ipv4_req), 160'(0));
		check("mac_tx.v", 160'(mac_tx.v), 160'(1'b0));
		check("mac_tx.sof", 160'(mac_tx.sof), 160'(1'b0));
		check("ipv4_rx_o.v", 160'(ipv4_rx_o.v), 160'(1'b0));
		check("ipv4_rx_o.sof", 160'(ipv4_rx_o.sof), 160'(1'b0));
		check("ipv4_rx_o.eof", 160'(ipv4_rx_o.eof), 160'(1'b0));
		check("ipv4_rx_o.err", 160'(ipv4_rx_o.err), 160'(1'b0));
		foreach (stim_q[i]) begin
			send_packet(stim_q[i]);
			repeat (2) @(negedge clk);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule
